/* flist.f */
+incdir+hdl
hdl/pixel_pkg.sv
hdl/scan_pkg.sv
hdl/line_buffer_ram.sv
hdl/line_writer.sv
hdl/pixel_doubler.sv
hdl/vga_scan_gen.sv
hdl/scan_doubler.sv
tests/scan_doubler_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0 --Wno-fatal
TOP       ?= scan_doubler_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := All tests passed!

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

$(OBJ_DIR)/V$(TOP): $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

test: $(OBJ_DIR)/V$(TOP)
	@./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)" \
		&& echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(OBJ_DIR)

/* tests/scan_doubler_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "scan_defs.svh"

module scan_doubler_tb;

    localparam int NUM_LINES  = 24;
    localparam int FRAME_LEN  = 8;    // source lines per frame including one vblank line
    localparam int BLANK_CYC  = 128;  // clk_rgb cycles of horizontal blanking
    localparam int LEAD_CYC   = 36;   // idle cycles before the first pixel
    localparam int TAIL_CYC   = 3;
    localparam int LINE_NS    = 10 * (BLANK_CYC + 1 + LEAD_CYC + 512 + TAIL_CYC);
    localparam int FIRST_PIX  = `FRONT_LEN + `LEFT_LEN + 2; // vga cycles from hsync rise to pixel
    localparam int WATCHDOG_NS = (NUM_LINES + 2) * LINE_NS + 20000;

    logic clk_rgb = 1'b0;
    logic clk_vga = 1'b0;
    logic rst = 1'b1;
    logic cen6 = 1'b0;
    logic [3:0] red = '0;
    logic [3:0] green = '0;
    logic [3:0] blue = '0;
    logic LHBL = 1'b1;
    logic LVBL = 1'b1;
    logic en_mixing = 1'b0;
    wire [4:0] vga_red;
    wire [4:0] vga_green;
    wire [4:0] vga_blue;
    wire vga_hsync;
    wire vga_vsync;

    int seed = 28;
    logic [11:0] wr_line [0:255];  // line being sent now
    logic [11:0] cur_line [0:255]; // last complete line
    logic [11:0] old_line [0:255]; // the one before it

    logic hs_prev = 1'b1;
    logic vs_prev = 1'b1;
    logic lhbl_prev = 1'b1;
    logic lvbl_prev = 1'b1;
    logic new_pair = 1'b0;
    logic is_first = 1'b0;
    logic vs_armed = 1'b0;
    int pos = 100000;
    int hs_low = 0;
    int since_rise = 100000;
    int rise_cnt = 0;
    int hs_per_line = 0;
    int vs_lines = 0;
    int vs_pulses = 0;

    always #5 clk_rgb = ~clk_rgb;
    always #2 clk_vga = ~clk_vga;

    scan_doubler scan_doubler_i (
        .clk_rgb   (clk_rgb),
        .cen6      (cen6),
        .clk_vga   (clk_vga),
        .rst       (rst),
        .red       (red),
        .green     (green),
        .blue      (blue),
        .LHBL      (LHBL),
        .LVBL      (LVBL),
        .en_mixing (en_mixing),
        .vga_red   (vga_red),
        .vga_green (vga_green),
        .vga_blue  (vga_blue),
        .vga_hsync (vga_hsync),
        .vga_vsync (vga_vsync)
    );

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("ERR %0t: %s, got %0h expected %0h", $time, what, got, exp);
            $display("Test failures found");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    // 4 to 5 bits with the msb copied below the lsb
    function automatic logic [4:0] widen(input logic [3:0] c);
        widen = {c, c[3]};
    endfunction

    function automatic logic [4:0] mean5(input logic [4:0] a, input logic [4:0] b);
        mean5 = ({1'b0, a} + {1'b0, b}) >> 1;
    endfunction

    // channel c of doubled output pixel j taken from a stored line
    function automatic logic [4:0] dbl_ch(input bit use_old, input int j, input int c,
                                          input bit mix);
        int p;
        int q;
        logic [11:0] a;
        logic [11:0] b;
        p = j / 2;
        q = (p == 255) ? 255 : p + 1; // last pixel blends with itself
        a = use_old ? old_line[p] : cur_line[p];
        b = use_old ? old_line[q] : cur_line[q];
        if ((j % 2 == 1) && mix) begin
            dbl_ch = mean5(widen(a[11-4*c -: 4]), widen(b[11-4*c -: 4]));
        end else begin
            dbl_ch = widen(a[11-4*c -: 4]);
        end
    endfunction

    always @(negedge clk_vga) begin
        logic hs_fall;
        logic hs_rise;
        logic vs_fall;
        logic vs_rise;
        logic [14:0] got;
        logic [4:0] exp_c;
        int j;
        if (!rst) begin
            hs_fall = hs_prev && !vga_hsync;
            hs_rise = !hs_prev && vga_hsync;
            vs_fall = vs_prev && !vga_vsync;
            vs_rise = !vs_prev && vga_vsync;
            got = {vga_red, vga_green, vga_blue};
            if (!lhbl_prev && LHBL) begin
                rise_cnt++;
                if (rise_cnt >= 3) begin
                    check_eq(hs_per_line, 2, "hsync pulses per source line");
                end
                hs_per_line = 0;
                since_rise = 0;
                new_pair = 1'b1; // first vga line of the pair comes next
            end else begin
                since_rise++;
            end
            if (hs_fall) hs_per_line++;
            if (!vga_hsync) hs_low++;
            if (hs_rise) begin
                if (rise_cnt >= 2 && since_rise > 40) begin
                    check_eq(hs_low, `SYNC_LEN, "free running hsync width");
                end
                hs_low = 0;
                pos = 0;
            end else if (pos < 100000) begin
                pos++;
            end
            if (pos >= FIRST_PIX && pos < FIRST_PIX + 512) begin
                j = pos - FIRST_PIX;
                if (j == 0) begin
                    is_first = new_pair;
                    new_pair = 1'b0;
                end
                if (rise_cnt >= 3) begin
                    for (int c = 0; c < 3; c++) begin
                        if (is_first && en_mixing) begin
                            exp_c = mean5(dbl_ch(0, j, c, 1'b1), dbl_ch(1, j, c, 1'b1));
                        end else begin
                            exp_c = dbl_ch(0, j, c, en_mixing);
                        end
                        check_eq(got[14-5*c -: 5], exp_c, "active pixel channel");
                    end
                end
            end else begin
                check_eq(got, 0, "colour outside active video");
            end
            if (lvbl_prev && !LVBL) vs_armed = 1'b1;
            if (vs_fall) begin
                check_eq(hs_fall, 1, "vsync start on hsync start");
                check_eq(vs_armed, 1, "vsync without vblank");
                vs_armed = 1'b0;
                vs_lines = 0;
            end else if (hs_fall && !vga_vsync) begin
                vs_lines++;
            end
            if (vs_rise) begin
                check_eq(hs_fall, 1, "vsync end on hsync start");
                check_eq(vs_lines, 1, "hsync pulses inside vsync");
                vs_pulses++;
            end
        end else begin
            check_eq({vga_hsync, vga_vsync}, 2'b11, "sync level in reset");
        end
        hs_prev = vga_hsync;
        vs_prev = vga_vsync;
        lhbl_prev = LHBL;
        lvbl_prev = LVBL;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the run went past its expected length");
        $display("Test failures found");
        $fatal(1, "watchdog expired");
    end

    initial begin
        repeat (3) @(posedge clk_vga);
        rst <= 1'b0;
        check_eq({vga_red, vga_green, vga_blue}, 0, "colour after reset");
        repeat (4) @(posedge clk_rgb);
        for (int n = 0; n < NUM_LINES; n++) begin
            @(posedge clk_rgb);
            LHBL <= 1'b0;
            LVBL <= (n % FRAME_LEN != FRAME_LEN - 1);
            repeat (BLANK_CYC - 1) @(posedge clk_rgb);
            @(posedge clk_rgb);
            LHBL <= 1'b1;
            en_mixing <= 1'($random(seed));
            for (int i = 0; i < 256; i++) begin
                old_line[i] = cur_line[i];
                cur_line[i] = wr_line[i];
            end
            repeat (LEAD_CYC) @(posedge clk_rgb);
            for (int i = 0; i < 256; i++) begin
                @(posedge clk_rgb);
                wr_line[i] = 12'($random(seed));
                {red, green, blue} <= wr_line[i];
                cen6 <= 1'b1;
                @(posedge clk_rgb);
                cen6 <= 1'b0;
            end
            repeat (TAIL_CYC) @(posedge clk_rgb);
        end
        repeat (40) @(posedge clk_vga);
        if (vs_pulses >= 2 && rise_cnt == NUM_LINES) begin
            $display("All tests passed!");
        end else begin
            $display("missing vsync pulses or source lines, %0d vsync, %0d lines",
                     vs_pulses, rise_cnt);
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* hdl/scan_doubler.sv */
`timescale 1ns/1ps
`default_nettype none

`include "scan_defs.svh"

module scan_doubler
    import pixel_pkg::*;
(
    input  wire                    clk_rgb,
    input  wire                    cen6,
    input  wire                    clk_vga,
    input  wire                    rst,
    input  wire  [`SRC_CH_W-1:0]   red,
    input  wire  [`SRC_CH_W-1:0]   green,
    input  wire  [`SRC_CH_W-1:0]   blue,
    input  wire                    LHBL,
    input  wire                    LVBL,
    input  wire                    en_mixing,
    output logic [`VGA_CH_W-1:0]   vga_red,
    output logic [`VGA_CH_W-1:0]   vga_green,
    output logic [`VGA_CH_W-1:0]   vga_blue,
    output logic                   vga_hsync,
    output logic                   vga_vsync
);

    logic [`LB_AW-1:0] wr_addr;
    logic              wr_bank;
    logic [`LB_AW-1:0] rd_addr;
    logic              dbl_phase;
    logic              rd_bank;
    logic              scanline;
    logic              line_active;

    logic [2:0]        sync_meta;  // {bank, LVBL, LHBL}
    logic [2:0]        sync_q;
    logic              lhbl_vga;
    logic              lvbl_vga;
    logic              bank_vga;

    logic              dbl_phase_d;
    logic [1:0]        active_d;   // matches RAM and doubler latency

    src_rgb_t          buf0_rgb;
    src_rgb_t          buf1_rgb;
    vga_rgb_t          dbl0_rgb;
    vga_rgb_t          dbl1_rgb;
    vga_rgb_t          sel_rgb;

    always_ff @(posedge clk_vga) begin
        sync_meta <= {wr_bank, LVBL, LHBL};
        sync_q    <= sync_meta;
    end

    assign lhbl_vga = sync_q[0];
    assign lvbl_vga = sync_q[1];
    assign bank_vga = sync_q[2];

    line_writer u_writer (
        .clk_rgb (clk_rgb),
        .rst     (rst),
        .cen6    (cen6),
        .LHBL    (LHBL),
        .wr_addr (wr_addr),
        .wr_bank (wr_bank)
    );

    line_buffer_ram #(.data_w(`SRC_PIX_W), .addr_w(`LB_AW)) u_buf0 (
        .clk_wr  (clk_rgb),
        .wr_cen  (cen6),
        .wr_en   (!bank_vga && lhbl_vga),
        .wr_addr (wr_addr),
        .wr_data ({red, green, blue}),
        .clk_rd  (clk_vga),
        .rd_addr (rd_addr),
        .rd_data (buf0_rgb)
    );

    line_buffer_ram #(.data_w(`SRC_PIX_W), .addr_w(`LB_AW)) u_buf1 (
        .clk_wr  (clk_rgb),
        .wr_cen  (cen6),
        .wr_en   (bank_vga && lhbl_vga),
        .wr_addr (wr_addr),
        .wr_data ({red, green, blue}),
        .clk_rd  (clk_vga),
        .rd_addr (rd_addr),
        .rd_data (buf1_rgb)
    );

    vga_scan_gen u_scan (
        .clk_vga     (clk_vga),
        .rst         (rst),
        .lhbl_sync   (lhbl_vga),
        .lvbl_sync   (lvbl_vga),
        .hsync       (vga_hsync),
        .vsync       (vga_vsync),
        .rd_addr     (rd_addr),
        .dbl_phase   (dbl_phase),
        .rd_bank     (rd_bank),
        .scanline    (scanline),
        .line_active (line_active)
    );

    pixel_doubler u_dbl0 (
        .clk_vga   (clk_vga),
        .dbl_phase (dbl_phase_d),
        .en_mix    (en_mixing),
        .rgb_in    (buf0_rgb),
        .rgb_out   (dbl0_rgb)
    );

    pixel_doubler u_dbl1 (
        .clk_vga   (clk_vga),
        .dbl_phase (dbl_phase_d),
        .en_mix    (en_mixing),
        .rgb_in    (buf1_rgb),
        .rgb_out   (dbl1_rgb)
    );

    // buffer b is written while the bank is b, so read the other one
    assign sel_rgb = rd_bank ? dbl0_rgb : dbl1_rgb;

    always_ff @(posedge clk_vga) begin
        if (rst) begin
            dbl_phase_d <= 1'b0;
            active_d    <= '0;
            vga_red     <= '0;
            vga_green   <= '0;
            vga_blue    <= '0;
        end else begin
            dbl_phase_d <= dbl_phase;
            active_d    <= {active_d[0], line_active};
            if (!active_d[1]) begin
                vga_red   <= '0; // blank outside the active window
                vga_green <= '0;
                vga_blue  <= '0;
            end else if (scanline && en_mixing) begin
                vga_red   <= avg_ch(dbl0_rgb.r, dbl1_rgb.r);
                vga_green <= avg_ch(dbl0_rgb.g, dbl1_rgb.g);
                vga_blue  <= avg_ch(dbl0_rgb.b, dbl1_rgb.b);
            end else begin
                vga_red   <= sel_rgb.r;
                vga_green <= sel_rgb.g;
                vga_blue  <= sel_rgb.b;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/vga_scan_gen.sv */
`timescale 1ns/1ps
`default_nettype none

`include "scan_defs.svh"

module vga_scan_gen
    import scan_pkg::*;
(
    input  wire                clk_vga,
    input  wire                rst,
    input  wire                lhbl_sync,
    input  wire                lvbl_sync,
    output logic               hsync,
    output logic               vsync,
    output logic [`LB_AW-1:0]  rd_addr,
    output logic               dbl_phase,
    output logic               rd_bank,
    output logic               scanline,
    output logic               line_active
);

    localparam int CNT_W = 7;

    scan_state_t       state;
    logic [CNT_W-1:0]  cnt;
    logic [`LB_AW-1:0] pix_addr;
    logic              seg_active;
    logic              seg_right;
    logic              locked;     // this line waits for the source
    logic              lhbl_last;
    logic              lvbl_last;
    logic              vsync_req;
    logic              vsync_hold;
    logic              last_pix;
    logic              sync_done;

    assign last_pix    = &pix_addr;
    assign line_active = (state == LINE) && seg_active;
    assign sync_done   = locked ? (lhbl_sync && !lhbl_last) : (cnt == '0);

    // repeated half prefetches the right neighbour, the last pixel stays put
    assign rd_addr = (dbl_phase && !last_pix) ? pix_addr + 1'b1 : pix_addr;

    always_ff @(posedge clk_vga) begin
        if (rst) begin
            state      <= SYNC;
            cnt        <= CNT_W'(`SYNC_LEN - 1);
            pix_addr   <= '0;
            dbl_phase  <= 1'b0;
            seg_active <= 1'b0;
            seg_right  <= 1'b0;
            locked     <= 1'b1;
            hsync      <= 1'b1;
            vsync      <= 1'b1;
            vsync_hold <= 1'b1;
            vsync_req  <= 1'b0;
            rd_bank    <= 1'b0;
            scanline   <= 1'b0;
            lhbl_last  <= 1'b0;
            lvbl_last  <= 1'b1;
        end else begin
            lhbl_last <= lhbl_sync;
            lvbl_last <= lvbl_sync;
            vsync_req <= !vsync ? 1'b0 : (vsync_req || (lvbl_last && !lvbl_sync));
            case (state)
                SYNC: begin
                    hsync <= 1'b0;
                    if (hsync) begin // first cycle of the pulse
                        if (vsync_req) begin
                            vsync      <= 1'b0;
                            vsync_hold <= 1'b0;
                        end else begin
                            vsync      <= vsync_hold; // second line keeps it low
                            vsync_hold <= 1'b1;
                        end
                    end
                    cnt <= cnt - 1'b1;
                    if (sync_done) begin
                        state    <= FRONT;
                        cnt      <= CNT_W'(`FRONT_LEN - 1);
                        locked   <= !locked;
                        scanline <= !scanline;
                        if (locked) begin
                            rd_bank <= !rd_bank; // new line pair
                        end
                    end
                end
                FRONT: begin
                    hsync <= 1'b1;
                    cnt   <= cnt - 1'b1;
                    if (cnt == '0) begin
                        state      <= LINE;
                        cnt        <= CNT_W'(`LEFT_LEN - 1);
                        pix_addr   <= '0;
                        dbl_phase  <= 1'b0;
                        seg_active <= 1'b0;
                        seg_right  <= 1'b0;
                    end
                end
                LINE: begin
                    if (seg_right) begin
                        if (cnt == '0) begin
                            state     <= BACK;
                            cnt       <= CNT_W'(`BACK_LEN - 1);
                            seg_right <= 1'b0;
                        end else begin
                            cnt <= cnt - 1'b1;
                        end
                    end else if (seg_active) begin
                        {pix_addr, dbl_phase} <= {pix_addr, dbl_phase} + 1'b1;
                        if (last_pix && dbl_phase) begin
                            seg_active <= 1'b0;
                            seg_right  <= 1'b1;
                            cnt        <= CNT_W'(`RIGHT_LEN - 1);
                        end
                    end else if (cnt == '0) begin
                        seg_active <= 1'b1; // left border done
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                BACK: begin
                    cnt <= cnt - 1'b1;
                    if (cnt == '0) begin
                        state <= SYNC;
                        cnt   <= CNT_W'(`SYNC_LEN - 1);
                    end
                end
                default: state <= SYNC;
            endcase
        end
    end

endmodule

`default_nettype wire

/* hdl/pixel_doubler.sv */
`timescale 1ns/1ps
`default_nettype none

module pixel_doubler
    import pixel_pkg::*;
(
    input  wire       clk_vga,
    input  wire       dbl_phase,
    input  wire       en_mix,
    input  src_rgb_t  rgb_in,
    output vga_rgb_t  rgb_out
);

    src_rgb_t prev;
    src_rgb_t cur;
    vga_rgb_t mixed;
    logic     blend;

    // on the repeated half rgb_in already carries the right neighbour
    always_comb begin
        cur   = dbl_phase ? prev : rgb_in;
        blend = dbl_phase && en_mix;
        if (blend) begin
            mixed.r = avg_ch(expand_ch(cur.r), expand_ch(rgb_in.r));
            mixed.g = avg_ch(expand_ch(cur.g), expand_ch(rgb_in.g));
            mixed.b = avg_ch(expand_ch(cur.b), expand_ch(rgb_in.b));
        end else begin
            mixed.r = expand_ch(cur.r);
            mixed.g = expand_ch(cur.g);
            mixed.b = expand_ch(cur.b);
        end
    end

    always_ff @(posedge clk_vga) begin
        prev    <= rgb_in;
        rgb_out <= mixed;
    end

endmodule

`default_nettype wire

/* hdl/line_writer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "scan_defs.svh"

module line_writer (
    input  wire                clk_rgb,
    input  wire                rst,
    input  wire                cen6,
    input  wire                LHBL,
    output logic [`LB_AW-1:0]  wr_addr,
    output logic               wr_bank
);

    logic lhbl_last;

    always_ff @(posedge clk_rgb) begin
        if (rst) begin
            wr_addr   <= '0;
            wr_bank   <= 1'b0;
            lhbl_last <= 1'b0;
        end else begin
            lhbl_last <= LHBL;
            if (!LHBL) begin
                wr_addr <= '0; // rewind during blanking
                if (lhbl_last) begin
                    wr_bank <= !wr_bank; // entering blanking, swap buffers
                end
            end else if (cen6) begin
                wr_addr <= wr_addr + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/line_buffer_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module line_buffer_ram #(
    parameter int data_w = 12,
    parameter int addr_w = 8
) (
    input  wire               clk_wr,
    input  wire               wr_cen,
    input  wire               wr_en,
    input  wire  [addr_w-1:0] wr_addr,
    input  wire  [data_w-1:0] wr_data,
    input  wire               clk_rd,
    input  wire  [addr_w-1:0] rd_addr,
    output logic [data_w-1:0] rd_data
);

    logic [data_w-1:0] mem [0:(1 << addr_w) - 1];

    // source side, one pixel per clock enable
    always_ff @(posedge clk_wr) begin
        if (wr_cen && wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // registered read, one cycle of latency
    always_ff @(posedge clk_rd) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

/* hdl/scan_pkg.sv */
`default_nettype none

package scan_pkg;

    // phases of one VGA line
    typedef enum logic [1:0] {
        SYNC  = 2'd0,
        FRONT = 2'd1,
        LINE  = 2'd2,
        BACK  = 2'd3
    } scan_state_t;

endpackage

`default_nettype wire

/* hdl/pixel_pkg.sv */
`default_nettype none

`include "scan_defs.svh"

package pixel_pkg;

    typedef struct packed {
        logic [`SRC_CH_W-1:0] r;
        logic [`SRC_CH_W-1:0] g;
        logic [`SRC_CH_W-1:0] b;
    } src_rgb_t;

    typedef struct packed {
        logic [`VGA_CH_W-1:0] r;
        logic [`VGA_CH_W-1:0] g;
        logic [`VGA_CH_W-1:0] b;
    } vga_rgb_t;

    // msb repeated below the lsb keeps full scale at 31
    function automatic logic [`VGA_CH_W-1:0] expand_ch(input logic [`SRC_CH_W-1:0] ch);
        return {ch, ch[`SRC_CH_W-1]};
    endfunction

    function automatic logic [`VGA_CH_W-1:0] avg_ch(input logic [`VGA_CH_W-1:0] a,
                                                    input logic [`VGA_CH_W-1:0] b);
        logic [`VGA_CH_W:0] sum;
        sum = {1'b0, a} + {1'b0, b};
        return sum[`VGA_CH_W:1]; // truncated mean
    endfunction

endpackage

`default_nettype wire

/* hdl/scan_defs.svh */
`ifndef SCAN_DEFS_SVH
`define SCAN_DEFS_SVH

// line buffer depth, one source line of 256 pixels
`define LB_AW 8

// channel and pixel widths
`define SRC_CH_W 4
`define VGA_CH_W 5
`define SRC_PIX_W 12

// VGA line phases, in clk_vga cycles
`define SYNC_LEN 96
`define FRONT_LEN 16
`define LEFT_LEN 64
`define RIGHT_LEN 61
`define BACK_LEN 48

`endif
